// File: logic/host_msg_pkg.sv
package host_msg_pkg;

	// Host link word and control-register word
	typedef logic [31:0] item_t;
	typedef logic [31:0] register_t;

	// Command codes carried in the first word of a host message
	typedef enum logic [31:0] {
		GET_CONTROL_REGISTER = 32'd2,
		SET_CONTROL_REGISTER = 32'd3,
		GET_CONSOLE_STATUS   = 32'd4,
		GET_CONSOLE_DATA     = 32'd5,
		WRITE_CONSOLE_DATA   = 32'd6
	} host_cmd_t;

	typedef enum logic [2:0] {
		IDLE,
		READ_CR_WAIT_INDEX,
		READ_CR_SEND,
		WRITE_CR_WAIT_INDEX,
		WRITE_CR_WAIT_DATA,
		CONSOLE_STATUS_SEND,
		CONSOLE_DATA_SEND,
		CONSOLE_WRITE_WAIT
	} host_state_t;

endpackage

// File: logic/io_map_pkg.sv
package io_map_pkg;

	typedef logic [2:0]  thread_id_t;
	typedef logic [31:0] io_addr_t;
	typedef logic [31:0] io_data_t;
	typedef logic [7:0]  console_byte_t;

	// Load/store direction of a core IO request
	typedef enum logic {
		IO_READ  = 1'b0,
		IO_WRITE = 1'b1
	} io_op_t;

	// Memory-mapped console registers
	localparam io_addr_t IO_MAP_BASE         = 32'hFF00_0000;
	localparam io_addr_t CONSOLE_DATA_ADDR   = IO_MAP_BASE + 32'd0;
	localparam io_addr_t CONSOLE_STATUS_ADDR = IO_MAP_BASE + 32'd4;

	// Status register value when bytes are waiting
	localparam io_data_t CONSOLE_HAS_DATA = 32'd1;

endpackage

// File: logic/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
	parameter int WIDTH             = 8,
	parameter int DEPTH             = 8,
	parameter int ALMOST_FULL_LEVEL = 6
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             enqueue_i,
	input  logic [WIDTH-1:0] data_i,
	input  logic             dequeue_i,
	output logic [WIDTH-1:0] data_o,
	output logic             full_o,
	output logic             almost_full_o,
	output logic             empty_o
);

	localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]   mem [DEPTH];
	logic [PTR_W-1:0]   rd_ptr;
	logic [PTR_W-1:0]   wr_ptr;
	logic [COUNT_W-1:0] count;
	logic               do_enq;
	logic               do_deq;

	// Requests against a full or empty buffer are dropped
	assign do_enq = enqueue_i & ~full_o;
	assign do_deq = dequeue_i & ~empty_o;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_enq)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_deq)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_enq & ~do_deq)
				count <= count + 1'b1;
			else if (do_deq & ~do_enq)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_enq)
			mem[wr_ptr] <= data_i;
	end

	// Head word is visible without a read cycle
	assign data_o        = mem[rd_ptr];
	assign full_o        = (count == COUNT_W'(DEPTH));
	assign almost_full_o = (count >= COUNT_W'(ALMOST_FULL_LEVEL));
	assign empty_o       = (count == '0);

endmodule

// File: logic/host_command_fsm.sv
`timescale 1ns/10ps

module host_command_fsm (
	input  logic                      clk,
	input  logic                      reset,
	input  host_msg_pkg::item_t       item_data_i,
	input  logic                      item_valid_i,
	output logic                      item_avail_o,
	output host_msg_pkg::item_t       item_data_o,
	output logic                      item_valid_o,
	input  logic                      item_avail_i,
	output logic                      hr_read_valid_o,
	output logic                      hr_write_valid_o,
	output host_msg_pkg::register_t   cr_index_o,
	output host_msg_pkg::register_t   cr_write_data_o,
	input  host_msg_pkg::register_t   cr_response_i,
	input  io_map_pkg::console_byte_t to_host_byte_i,
	input  logic                      to_host_empty_i,
	output logic                      to_host_deq_o,
	input  logic                      from_host_full_i,
	output logic                      from_host_enq_o,
	output io_map_pkg::console_byte_t from_host_byte_o
);

	import host_msg_pkg::*;
	import io_map_pkg::*;

	host_state_t state;
	host_state_t next_state;
	register_t   write_index;
	logic        capture_index;

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Index of a pending control-register write
	always_ff @(posedge clk) begin
		if (capture_index)
			write_index <= item_data_i;
	end

	// Only the low byte of a console write word is kept
	assign from_host_byte_o = item_data_i[7:0];

	always_comb begin
		next_state       = state;
		item_avail_o     = 1'b0;
		item_valid_o     = 1'b0;
		item_data_o      = '0;
		hr_read_valid_o  = 1'b0;
		hr_write_valid_o = 1'b0;
		cr_index_o       = '0;
		cr_write_data_o  = '0;
		to_host_deq_o    = 1'b0;
		from_host_enq_o  = 1'b0;
		capture_index    = 1'b0;

		unique case (state)
			IDLE: begin
				item_avail_o = 1'b1;
				if (item_valid_i) begin
					case (host_cmd_t'(item_data_i))
						GET_CONTROL_REGISTER: next_state = READ_CR_WAIT_INDEX;
						SET_CONTROL_REGISTER: next_state = WRITE_CR_WAIT_INDEX;
						GET_CONSOLE_STATUS:   next_state = CONSOLE_STATUS_SEND;
						GET_CONSOLE_DATA:     next_state = CONSOLE_DATA_SEND;
						WRITE_CONSOLE_DATA:   next_state = CONSOLE_WRITE_WAIT;
						// Unknown codes are swallowed
						default:              next_state = IDLE;
					endcase
				end
			end

			READ_CR_WAIT_INDEX: begin
				item_avail_o = 1'b1;
				if (item_valid_i) begin
					hr_read_valid_o = 1'b1;
					cr_index_o      = item_data_i;
					next_state      = READ_CR_SEND;
				end
			end

			// Register file holds its answer until the word leaves
			READ_CR_SEND: begin
				item_valid_o = 1'b1;
				item_data_o  = cr_response_i;
				if (item_avail_i)
					next_state = IDLE;
			end

			WRITE_CR_WAIT_INDEX: begin
				item_avail_o = 1'b1;
				if (item_valid_i) begin
					capture_index = 1'b1;
					next_state    = WRITE_CR_WAIT_DATA;
				end
			end

			WRITE_CR_WAIT_DATA: begin
				item_avail_o = 1'b1;
				if (item_valid_i) begin
					hr_write_valid_o = 1'b1;
					cr_index_o       = write_index;
					cr_write_data_o  = item_data_i;
					next_state       = IDLE;
				end
			end

			CONSOLE_STATUS_SEND: begin
				item_valid_o = 1'b1;
				item_data_o  = {31'd0, ~to_host_empty_i};
				if (item_avail_i)
					next_state = IDLE;
			end

			CONSOLE_DATA_SEND: begin
				item_valid_o  = 1'b1;
				item_data_o   = {24'd0, to_host_byte_i};
				to_host_deq_o = item_avail_i & ~to_host_empty_i;
				if (item_avail_i)
					next_state = IDLE;
			end

			// Host is held off while the core has not drained the FIFO
			CONSOLE_WRITE_WAIT: begin
				item_avail_o = ~from_host_full_i;
				if (item_valid_i & ~from_host_full_i) begin
					from_host_enq_o = 1'b1;
					next_state      = IDLE;
				end
			end

			default: next_state = IDLE;
		endcase
	end

endmodule

// File: logic/io_console_bridge.sv
`timescale 1ns/10ps

module io_console_bridge (
	input  logic                      clk,
	input  logic                      reset,
	input  io_map_pkg::thread_id_t    req_thread_i,
	input  io_map_pkg::io_op_t        req_op_i,
	input  io_map_pkg::io_addr_t      req_addr_i,
	input  io_map_pkg::io_data_t      req_data_i,
	input  logic                      req_empty_i,
	output logic                      req_deq_o,
	input  logic                      to_host_full_i,
	output logic                      to_host_enq_o,
	output io_map_pkg::console_byte_t to_host_byte_o,
	input  io_map_pkg::console_byte_t from_host_byte_i,
	input  logic                      from_host_empty_i,
	output logic                      from_host_deq_o,
	output logic                      io_resp_valid_o,
	output io_map_pkg::thread_id_t    io_resp_thread_o,
	output io_map_pkg::io_data_t      io_resp_data_o,
	input  logic                      io_resp_consumed_i
);

	import io_map_pkg::*;

	typedef enum logic {
		IO_IDLE,
		IO_RESP
	} io_state_t;

	io_state_t io_state;
	io_data_t  read_data;
	io_data_t  resp_data;
	logic      resp_pop;
	logic      start_read;

	assign start_read = (io_state == IO_IDLE) & ~req_empty_i & (req_op_i == IO_READ);

	// Value a read of the head address would return right now
	always_comb begin
		if (req_addr_i == CONSOLE_DATA_ADDR)
			read_data = {24'd0, from_host_byte_i};
		else if (req_addr_i == CONSOLE_STATUS_ADDR)
			read_data = from_host_empty_i ? '0 : CONSOLE_HAS_DATA;
		else
			read_data = '0;
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			io_state <= IO_IDLE;
		end else begin
			case (io_state)
				IO_IDLE: if (start_read) io_state <= IO_RESP;
				IO_RESP: if (io_resp_consumed_i) io_state <= IO_IDLE;
				default: io_state <= IO_IDLE;
			endcase
		end
	end

	// Response is frozen so a late host byte cannot change it mid-handshake
	always_ff @(posedge clk) begin
		if (start_read) begin
			resp_data <= read_data;
			resp_pop  <= (req_addr_i == CONSOLE_DATA_ADDR) & ~from_host_empty_i;
		end
	end

	assign to_host_byte_o   = req_data_i[7:0];
	assign io_resp_valid_o  = (io_state == IO_RESP);
	assign io_resp_thread_o = req_thread_i;
	assign io_resp_data_o   = resp_data;

	always_comb begin
		req_deq_o       = 1'b0;
		to_host_enq_o   = 1'b0;
		from_host_deq_o = 1'b0;

		if (io_state == IO_IDLE) begin
			if (~req_empty_i & (req_op_i == IO_WRITE)) begin
				// Console byte waits at the head while the FIFO is full
				if (req_addr_i == CONSOLE_DATA_ADDR) begin
					to_host_enq_o = ~to_host_full_i;
					req_deq_o     = ~to_host_full_i;
				end else begin
					req_deq_o = 1'b1;
				end
			end
		end else begin
			req_deq_o       = io_resp_consumed_i;
			from_host_deq_o = io_resp_consumed_i & resp_pop;
		end
	end

endmodule

// File: logic/host_console_top.sv
`timescale 1ns/10ps

module host_console_top #(
	parameter int CONSOLE_DEPTH  = 8,
	parameter int IO_QUEUE_DEPTH = 4
) (
	input  logic                    clk,
	input  logic                    reset,
	input  host_msg_pkg::item_t     item_data_i,
	input  logic                    item_valid_i,
	output logic                    item_avail_o,
	output host_msg_pkg::item_t     item_data_o,
	output logic                    item_valid_o,
	input  logic                    item_avail_i,
	output logic                    hr_read_valid_o,
	output logic                    hr_write_valid_o,
	output host_msg_pkg::register_t cr_index_o,
	output host_msg_pkg::register_t cr_write_data_o,
	input  host_msg_pkg::register_t cr_response_i,
	input  logic                    io_req_valid_i,
	input  io_map_pkg::thread_id_t  io_req_thread_i,
	input  io_map_pkg::io_op_t      io_req_op_i,
	input  io_map_pkg::io_addr_t    io_req_addr_i,
	input  io_map_pkg::io_data_t    io_req_data_i,
	output logic                    io_available_o,
	output logic                    io_resp_valid_o,
	output io_map_pkg::thread_id_t  io_resp_thread_o,
	output io_map_pkg::io_data_t    io_resp_data_o,
	input  logic                    io_resp_consumed_i
);

	import io_map_pkg::*;

	localparam int REQ_WIDTH = $bits(thread_id_t) + $bits(io_op_t) + $bits(io_addr_t)
		+ $bits(io_data_t);

	logic [REQ_WIDTH-1:0] req_in;
	logic [REQ_WIDTH-1:0] req_head;
	thread_id_t           head_thread;
	logic                 head_op;
	io_addr_t             head_addr;
	io_data_t             head_data;
	logic                 req_empty;
	logic                 req_deq;
	logic                 queue_almost_full;

	console_byte_t to_host_in;
	console_byte_t to_host_out;
	logic          to_host_enq;
	logic          to_host_deq;
	logic          to_host_full;
	logic          to_host_empty;

	console_byte_t from_host_in;
	console_byte_t from_host_out;
	logic          from_host_enq;
	logic          from_host_deq;
	logic          from_host_full;
	logic          from_host_empty;

	assign req_in = {io_req_thread_i, io_req_op_i, io_req_addr_i, io_req_data_i};
	assign {head_thread, head_op, head_addr, head_data} = req_head;

	// Leaves room for requests already in flight from the load/store unit
	assign io_available_o = ~queue_almost_full;

	sync_fifo #(
		.WIDTH             (REQ_WIDTH),
		.DEPTH             (IO_QUEUE_DEPTH),
		.ALMOST_FULL_LEVEL (IO_QUEUE_DEPTH - 2)
	) io_request_queue (
		.clk           (clk),
		.reset         (reset),
		.enqueue_i     (io_req_valid_i & io_available_o),
		.data_i        (req_in),
		.dequeue_i     (req_deq),
		.data_o        (req_head),
		.full_o        (),
		.almost_full_o (queue_almost_full),
		.empty_o       (req_empty)
	);

	sync_fifo #(
		.WIDTH             ($bits(console_byte_t)),
		.DEPTH             (CONSOLE_DEPTH),
		.ALMOST_FULL_LEVEL (CONSOLE_DEPTH)
	) to_host_fifo (
		.clk           (clk),
		.reset         (reset),
		.enqueue_i     (to_host_enq),
		.data_i        (to_host_in),
		.dequeue_i     (to_host_deq),
		.data_o        (to_host_out),
		.full_o        (to_host_full),
		.almost_full_o (),
		.empty_o       (to_host_empty)
	);

	sync_fifo #(
		.WIDTH             ($bits(console_byte_t)),
		.DEPTH             (CONSOLE_DEPTH),
		.ALMOST_FULL_LEVEL (CONSOLE_DEPTH)
	) from_host_fifo (
		.clk           (clk),
		.reset         (reset),
		.enqueue_i     (from_host_enq),
		.data_i        (from_host_in),
		.dequeue_i     (from_host_deq),
		.data_o        (from_host_out),
		.full_o        (from_host_full),
		.almost_full_o (),
		.empty_o       (from_host_empty)
	);

	host_command_fsm host_command_fsm_i (
		.clk              (clk),
		.reset            (reset),
		.item_data_i      (item_data_i),
		.item_valid_i     (item_valid_i),
		.item_avail_o     (item_avail_o),
		.item_data_o      (item_data_o),
		.item_valid_o     (item_valid_o),
		.item_avail_i     (item_avail_i),
		.hr_read_valid_o  (hr_read_valid_o),
		.hr_write_valid_o (hr_write_valid_o),
		.cr_index_o       (cr_index_o),
		.cr_write_data_o  (cr_write_data_o),
		.cr_response_i    (cr_response_i),
		.to_host_byte_i   (to_host_out),
		.to_host_empty_i  (to_host_empty),
		.to_host_deq_o    (to_host_deq),
		.from_host_full_i (from_host_full),
		.from_host_enq_o  (from_host_enq),
		.from_host_byte_o (from_host_in)
	);

	io_console_bridge io_console_bridge_i (
		.clk                (clk),
		.reset              (reset),
		.req_thread_i       (head_thread),
		.req_op_i           (io_op_t'(head_op)),
		.req_addr_i         (head_addr),
		.req_data_i         (head_data),
		.req_empty_i        (req_empty),
		.req_deq_o          (req_deq),
		.to_host_full_i     (to_host_full),
		.to_host_enq_o      (to_host_enq),
		.to_host_byte_o     (to_host_in),
		.from_host_byte_i   (from_host_out),
		.from_host_empty_i  (from_host_empty),
		.from_host_deq_o    (from_host_deq),
		.io_resp_valid_o    (io_resp_valid_o),
		.io_resp_thread_o   (io_resp_thread_o),
		.io_resp_data_o     (io_resp_data_o),
		.io_resp_consumed_i (io_resp_consumed_i)
	);

endmodule

// File: dv/host_console_assertions.sv
`timescale 1ns/10ps

module host_console_assertions (
	input logic                 clk,
	input logic                 reset,
	input logic                 item_valid_o,
	input logic                 item_avail_o,
	input logic                 io_resp_valid_o,
	input io_map_pkg::io_data_t io_resp_data_o,
	input logic                 io_resp_consumed_i,
	input logic                 to_host_enq,
	input logic                 to_host_full,
	input logic                 from_host_enq,
	input logic                 from_host_full
);

	// Host link never offers and accepts in the same cycle
	link_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(item_valid_o && item_avail_o))
		else $error("host link valid and avail high together");

	resp_stable: assert property (@(posedge clk) disable iff (reset)
		(io_resp_valid_o && !io_resp_consumed_i) |=> (io_resp_valid_o && $stable(io_resp_data_o)))
		else $error("IO response changed before it was consumed");

	no_enq_when_full: assert property (@(posedge clk) disable iff (reset)
		!((to_host_enq && to_host_full) || (from_host_enq && from_host_full)))
		else $error("console FIFO enqueued while full");

endmodule

bind host_console_top host_console_assertions host_console_assertions_i (
	.clk                (clk),
	.reset              (reset),
	.item_valid_o       (item_valid_o),
	.item_avail_o       (item_avail_o),
	.io_resp_valid_o    (io_resp_valid_o),
	.io_resp_data_o     (io_resp_data_o),
	.io_resp_consumed_i (io_resp_consumed_i),
	.to_host_enq        (to_host_enq),
	.to_host_full       (to_host_full),
	.from_host_enq      (from_host_enq),
	.from_host_full     (from_host_full)
);

// File: dv/host_console_tb.sv
`timescale 1ns/10ps

module host_console_tb;

	import host_msg_pkg::*;
	import io_map_pkg::*;

	localparam int CONSOLE_DEPTH  = 8;
	localparam int IO_QUEUE_DEPTH = 4;
	localparam int CLK_PERIOD     = 8;
	// Roughly ten times the length of all tests together
	localparam int TIMEOUT_NS     = 20000;
	localparam int WAIT_LIMIT     = 64;

	logic       clk;
	logic       reset;
	item_t      item_data_i;
	logic       item_valid_i;
	logic       item_avail_o;
	item_t      item_data_o;
	logic       item_valid_o;
	logic       item_avail_i;
	logic       hr_read_valid_o;
	logic       hr_write_valid_o;
	register_t  cr_index_o;
	register_t  cr_write_data_o;
	register_t  cr_response_i;
	logic       io_req_valid_i;
	thread_id_t io_req_thread_i;
	io_op_t     io_req_op_i;
	io_addr_t   io_req_addr_i;
	io_data_t   io_req_data_i;
	logic       io_available_o;
	logic       io_resp_valid_o;
	thread_id_t io_resp_thread_o;
	io_data_t   io_resp_data_o;
	logic       io_resp_consumed_i;

	register_t  cr_regs [16];
	logic [3:0] cr_read_index;
	int         error_count;
	integer     seed;

	host_console_top #(
		.CONSOLE_DEPTH  (CONSOLE_DEPTH),
		.IO_QUEUE_DEPTH (IO_QUEUE_DEPTH)
	) host_console_top_i (
		.clk                (clk),
		.reset              (reset),
		.item_data_i        (item_data_i),
		.item_valid_i       (item_valid_i),
		.item_avail_o       (item_avail_o),
		.item_data_o        (item_data_o),
		.item_valid_o       (item_valid_o),
		.item_avail_i       (item_avail_i),
		.hr_read_valid_o    (hr_read_valid_o),
		.hr_write_valid_o   (hr_write_valid_o),
		.cr_index_o         (cr_index_o),
		.cr_write_data_o    (cr_write_data_o),
		.cr_response_i      (cr_response_i),
		.io_req_valid_i     (io_req_valid_i),
		.io_req_thread_i    (io_req_thread_i),
		.io_req_op_i        (io_req_op_i),
		.io_req_addr_i      (io_req_addr_i),
		.io_req_data_i      (io_req_data_i),
		.io_available_o     (io_available_o),
		.io_resp_valid_o    (io_resp_valid_o),
		.io_resp_thread_o   (io_resp_thread_o),
		.io_resp_data_o     (io_resp_data_o),
		.io_resp_consumed_i (io_resp_consumed_i)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Register file model samples the FSM pulses at the falling edge
	initial begin
		cr_response_i = '0;
		cr_read_index = '0;
		for (int i = 0; i < 16; i++)
			cr_regs[i] = '0;
		forever begin
			@(negedge clk);
			if (hr_write_valid_o)
				cr_regs[cr_index_o[3:0]] = cr_write_data_o;
			if (hr_read_valid_o) begin
				cr_read_index = cr_index_o[3:0];
				cr_response_i = cr_regs[cr_read_index];
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Result: FAILED");
		$finish;
	end

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("ERROR: %s", what);
		error_count++;
	endtask

	// Holds the word on the link until the DUT raises avail
	task automatic wait_host_accept();
		int   cycles;
		logic taken;
		cycles = 0;
		taken  = 1'b0;
		while (!taken && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			taken = item_avail_o;
			@(posedge clk);
			#1;
			cycles++;
		end
		item_valid_i = 1'b0;
		if (!taken)
			report_failure("host word was not accepted by the DUT");
	endtask

	task automatic send_item(input item_t data);
		item_data_i  = data;
		item_valid_i = 1'b1;
		wait_host_accept();
	endtask

	task automatic receive_item(output item_t data);
		int   cycles;
		logic seen;
		cycles       = 0;
		seen         = 1'b0;
		data         = '0;
		item_avail_i = 1'b1;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			if (item_valid_o) begin
				seen = 1'b1;
				data = item_data_o;
			end
			@(posedge clk);
			#1;
			cycles++;
		end
		item_avail_i = 1'b0;
		if (!seen)
			report_failure("no response word came from the DUT");
	endtask

	task automatic host_query(input item_t cmd, output item_t data);
		send_item(cmd);
		receive_item(data);
	endtask

	task automatic io_request(input thread_id_t thread, input io_op_t op, input io_addr_t addr,
		input io_data_t data);
		int   cycles;
		logic taken;
		cycles          = 0;
		taken           = 1'b0;
		io_req_thread_i = thread;
		io_req_op_i     = op;
		io_req_addr_i   = addr;
		io_req_data_i   = data;
		io_req_valid_i  = 1'b1;
		while (!taken && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			taken = io_available_o;
			@(posedge clk);
			#1;
			cycles++;
		end
		io_req_valid_i = 1'b0;
		if (!taken)
			report_failure("core IO request was not accepted by the DUT");
	endtask

	task automatic io_write(input io_addr_t addr, input io_data_t data);
		io_request(3'd0, IO_WRITE, addr, data);
	endtask

	task automatic io_read(input io_addr_t addr, input thread_id_t thread, output io_data_t data,
		output thread_id_t resp_thread);
		int   cycles;
		logic seen;
		cycles      = 0;
		seen        = 1'b0;
		data        = '0;
		resp_thread = '0;
		io_request(thread, IO_READ, addr, '0);
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			if (io_resp_valid_o) begin
				seen        = 1'b1;
				data        = io_resp_data_o;
				resp_thread = io_resp_thread_o;
			end
			@(posedge clk);
			#1;
			cycles++;
		end
		if (seen) begin
			io_resp_consumed_i = 1'b1;
			@(posedge clk);
			#1;
			io_resp_consumed_i = 1'b0;
		end else begin
			report_failure("core IO read got no response");
		end
	endtask

	task automatic test_control_registers();
		int        idx [3];
		register_t values [3];
		item_t     data;
		idx = '{3, 7, 12};
		for (int i = 0; i < 3; i++) begin
			values[i] = $random(seed);
			send_item(SET_CONTROL_REGISTER);
			send_item(item_t'(idx[i]));
			send_item(values[i]);
		end
		for (int i = 0; i < 3; i++) begin
			check_value("control_registers: model", values[i], cr_regs[idx[i]]);
			send_item(GET_CONTROL_REGISTER);
			send_item(item_t'(idx[i]));
			receive_item(data);
			check_value("control_registers: readback", cr_regs[idx[i]], data);
		end
	endtask

	task automatic test_host_to_core();
		io_data_t   rdata;
		thread_id_t rthread;
		item_t      words [2];
		io_read(CONSOLE_STATUS_ADDR, 3'd1, rdata, rthread);
		check_value("host_to_core: status empty", 32'd0, rdata);
		for (int i = 0; i < 2; i++) begin
			words[i] = $random(seed);
			send_item(WRITE_CONSOLE_DATA);
			send_item(words[i]);
		end
		io_read(CONSOLE_STATUS_ADDR, 3'd2, rdata, rthread);
		check_value("host_to_core: status full", 32'd1, rdata);
		for (int i = 0; i < 2; i++) begin
			io_read(CONSOLE_DATA_ADDR, 3'd4, rdata, rthread);
			check_value("host_to_core: byte", 32'(words[i][7:0]), rdata);
			check_value("host_to_core: thread", 32'd4, 32'(rthread));
		end
		io_read(CONSOLE_STATUS_ADDR, 3'd1, rdata, rthread);
		check_value("host_to_core: status drained", 32'd0, rdata);
	endtask

	task automatic test_core_to_host();
		io_data_t words [3];
		item_t    data;
		for (int i = 0; i < 3; i++) begin
			words[i] = $random(seed);
			io_write(CONSOLE_DATA_ADDR, words[i]);
		end
		host_query(GET_CONSOLE_STATUS, data);
		check_value("core_to_host: status full", 32'd1, data);
		for (int i = 0; i < 3; i++) begin
			host_query(GET_CONSOLE_DATA, data);
			check_value("core_to_host: byte", 32'(words[i][7:0]), data);
		end
		host_query(GET_CONSOLE_STATUS, data);
		check_value("core_to_host: status drained", 32'd0, data);
	endtask

	task automatic test_back_pressure();
		item_t      words [CONSOLE_DEPTH + 1];
		io_data_t   rdata;
		thread_id_t rthread;
		for (int i = 0; i <= CONSOLE_DEPTH; i++)
			words[i] = $random(seed);
		for (int i = 0; i < CONSOLE_DEPTH; i++) begin
			send_item(WRITE_CONSOLE_DATA);
			send_item(words[i]);
		end
		// FIFO is full, so the last data word must wait on the link
		send_item(WRITE_CONSOLE_DATA);
		item_data_i  = words[CONSOLE_DEPTH];
		item_valid_i = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_value("back_pressure: held off", 32'd0, 32'(item_avail_o));
			@(posedge clk);
			#1;
		end
		fork
			wait_host_accept();
			io_read(CONSOLE_DATA_ADDR, 3'd2, rdata, rthread);
		join
		check_value("back_pressure: first byte", 32'(words[0][7:0]), rdata);
		for (int i = 1; i <= CONSOLE_DEPTH; i++) begin
			io_read(CONSOLE_DATA_ADDR, 3'd2, rdata, rthread);
			check_value("back_pressure: byte", 32'(words[i][7:0]), rdata);
		end
	endtask

	task automatic test_other_addresses();
		io_data_t   rdata;
		thread_id_t rthread;
		item_t      data;
		io_read(IO_MAP_BASE + 32'h100, 3'd5, rdata, rthread);
		check_value("other_addresses: unmapped read", 32'd0, rdata);
		check_value("other_addresses: unmapped thread", 32'd5, 32'(rthread));
		io_write(IO_MAP_BASE + 32'h100, $random(seed));
		io_read(CONSOLE_STATUS_ADDR, 3'd3, rdata, rthread);
		check_value("other_addresses: core status", 32'd0, rdata);
		host_query(GET_CONSOLE_STATUS, data);
		check_value("other_addresses: host status", 32'd0, data);
		// No word may come back for an unknown code
		send_item(32'h0000_0017);
		item_avail_i = 1'b1;
		repeat (6) begin
			@(negedge clk);
			check_value("other_addresses: no output", 32'd0, 32'(item_valid_o));
			@(posedge clk);
			#1;
		end
		item_avail_i = 1'b0;
		send_item(GET_CONTROL_REGISTER);
		send_item(32'd3);
		receive_item(data);
		check_value("other_addresses: next command", cr_regs[3], data);
	endtask

	initial begin
		seed               = 32'hf5eca3b7;
		error_count        = 0;
		reset              = 1'b1;
		item_data_i        = '0;
		item_valid_i       = 1'b0;
		item_avail_i       = 1'b0;
		io_req_valid_i     = 1'b0;
		io_req_thread_i    = '0;
		io_req_op_i        = IO_READ;
		io_req_addr_i      = '0;
		io_req_data_i      = '0;
		io_resp_consumed_i = 1'b0;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		@(posedge clk);
		#1;
		test_control_registers();
		test_host_to_core();
		test_core_to_host();
		test_back_pressure();
		test_other_addresses();
		$display("Errors: %0d", error_count);
		if (error_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: sim.f
logic/host_msg_pkg.sv
logic/io_map_pkg.sv
logic/sync_fifo.sv
logic/host_command_fsm.sv
logic/io_console_bridge.sv
logic/host_console_top.sv
dv/host_console_assertions.sv
dv/host_console_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = host_console_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation failed"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
